// ==== logic/soc_pkg.sv ====
// soc package: address map, bus sizes, interrupt sizes, boot image and timer type
package soc_pkg;

  // ----------------------------------------
  // bus
  // ----------------------------------------
  localparam int unsigned bus_addr_w = 32;
  localparam int unsigned bus_data_w = 32;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam logic [bus_addr_w-1:0] rom_base     = 32'h0001_0000;
  localparam logic [bus_addr_w-1:0] rom_length   = 32'h0001_0000;
  localparam logic [bus_addr_w-1:0] clint_base   = 32'h0200_0000;
  localparam logic [bus_addr_w-1:0] clint_length = 32'h000C_0000;
  localparam logic [bus_addr_w-1:0] plic_base    = 32'h0C00_0000;
  localparam logic [bus_addr_w-1:0] plic_length  = 32'h0400_0000;

  // clint registers, 64-bit ones have hi half at +4
  localparam logic [bus_addr_w-1:0] clint_msip_off     = 32'h0000_0000;
  localparam logic [bus_addr_w-1:0] clint_mtimecmp_off = 32'h0000_4000;
  localparam logic [bus_addr_w-1:0] clint_mtime_off    = 32'h0000_BFF8;

  // plic registers, priority of source id at 4*id
  localparam logic [bus_addr_w-1:0] plic_pending_off   = 32'h0000_1000;
  localparam logic [bus_addr_w-1:0] plic_enable_off    = 32'h0000_2000;
  localparam logic [bus_addr_w-1:0] plic_threshold_off = 32'h0020_0000;
  localparam logic [bus_addr_w-1:0] plic_claim_off     = 32'h0020_0004;

  // ----------------------------------------
  // interrupts
  // ----------------------------------------
  // ids 1..7, id 0 is no interrupt
  localparam int unsigned num_sources_default = 7;
  localparam int unsigned prio_w = 3;

  // ----------------------------------------
  // boot image
  // ----------------------------------------
  localparam int unsigned rom_words = 16;

  localparam logic [bus_data_w-1:0] boot_image [rom_words] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283,
    32'h0002_8067, 32'h0000_0013, 32'h1050_0073, 32'hffdf_f06f,
    32'h8000_0000, 32'hd00d_feed, 32'h0000_0a10, 32'h0000_0038,
    32'h0000_09d4, 32'h0000_0028, 32'h0000_0011, 32'h0000_0010
  };

  // 64-bit timer register, accessed whole or as two bus words
  typedef union packed {
    logic [63:0] val;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } timer64_u;

endpackage

// ==== logic/periph_decode.sv ====
// address decoder: steers bus requests to rom, clint or plic and returns read data
`timescale 1ns/1ps

module periph_decode (
  input  logic                           clk,
  input  logic                           ndmreset_n,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [soc_pkg::bus_addr_w-1:0] addr_i,
  input  logic [soc_pkg::bus_data_w-1:0] wdata_i,
  input  logic [soc_pkg::bus_data_w-1:0] rom_rdata_i,
  input  logic [soc_pkg::bus_data_w-1:0] clint_rdata_i,
  input  logic [soc_pkg::bus_data_w-1:0] plic_rdata_i,
  output logic                           rom_req_o,
  output logic                           clint_req_o,
  output logic                           plic_req_o,
  output logic                           we_o,
  output logic [soc_pkg::bus_addr_w-1:0] offset_o,
  output logic [soc_pkg::bus_data_w-1:0] wdata_o,
  output logic [soc_pkg::bus_data_w-1:0] rdata_o,
  output logic                           rvalid_o,
  output logic                           err_o
);
  import soc_pkg::*;

  logic       rom_hit;
  logic       clint_hit;
  logic       plic_hit;
  logic       bad_access;
  logic [2:0] sel_q;
  logic       rd_q;
  logic       rvalid_q;
  logic       err_q;

  // ----------------------------------------
  // region match
  // ----------------------------------------
  assign rom_hit   = (addr_i >= rom_base) && (addr_i < rom_base + rom_length);
  assign clint_hit = (addr_i >= clint_base) && (addr_i < clint_base + clint_length);
  assign plic_hit  = (addr_i >= plic_base) && (addr_i < plic_base + plic_length);

  // rom is read-only
  assign bad_access = !(rom_hit || clint_hit || plic_hit) || (rom_hit && we_i);

  assign rom_req_o   = req_i & rom_hit & ~we_i;
  assign clint_req_o = req_i & clint_hit;
  assign plic_req_o  = req_i & plic_hit;
  assign we_o        = we_i;
  assign wdata_o     = wdata_i;

  always_comb begin
    if (rom_hit) begin
      offset_o = addr_i - rom_base;
    end else if (clint_hit) begin
      offset_o = addr_i - clint_base;
    end else if (plic_hit) begin
      offset_o = addr_i - plic_base;
    end else begin
      offset_o = '0;
    end
  end

  // ----------------------------------------
  // response
  // ----------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      sel_q    <= '0;
      rd_q     <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      sel_q    <= {plic_req_o, clint_req_o, rom_req_o};
      rd_q     <= req_i & ~we_i;
      rvalid_q <= req_i;
      err_q    <= req_i & bad_access;
    end
  end

  // sel_q is empty after an error, so rdata stays zero
  assign rdata_o = rd_q ? (({bus_data_w{sel_q[0]}} & rom_rdata_i) |
                           ({bus_data_w{sel_q[1]}} & clint_rdata_i) |
                           ({bus_data_w{sel_q[2]}} & plic_rdata_i)) : '0;
  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

// ==== logic/boot_rom.sv ====
// boot rom holding the fixed boot image, one registered read port
`timescale 1ns/1ps

module boot_rom (
  input  logic                           clk,
  input  logic                           req_i,
  input  logic [soc_pkg::bus_addr_w-1:0] offset_i,
  output logic [soc_pkg::bus_data_w-1:0] rdata_o
);
  import soc_pkg::*;

  localparam int unsigned idx_w = $clog2(rom_words);

  logic [idx_w-1:0]      word_idx;
  logic [bus_data_w-1:0] rdata_q;

  // byte offset to word index, wraps at rom_words
  assign word_idx = offset_i[idx_w+1:2];

  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_q <= boot_image[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== logic/clint.sv ====
// core-local interruptor: half-rate rtc, machine timer, compare and software interrupt
`timescale 1ns/1ps

module clint (
  input  logic                           clk,
  input  logic                           ndmreset_n,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [soc_pkg::bus_addr_w-1:0] offset_i,
  input  logic [soc_pkg::bus_data_w-1:0] wdata_i,
  output logic [soc_pkg::bus_data_w-1:0] rdata_o,
  output logic                           timer_irq_o,
  output logic                           ipi_o
);
  import soc_pkg::*;

  logic                  rtc_q;
  logic                  rtc_d1_q;
  logic                  rtc_tick;
  logic                  wr_en;
  logic                  rd_en;
  timer64_u              mtime_q;
  timer64_u              mtime_d;
  timer64_u              mtimecmp_q;
  timer64_u              mtimecmp_d;
  logic                  msip_q;
  logic [bus_data_w-1:0] rd_data;
  logic [bus_data_w-1:0] rdata_q;

  assign wr_en = req_i & we_i;
  assign rd_en = req_i & ~we_i;

  // ----------------------------------------
  // real-time tick
  // ----------------------------------------
  // rtc runs at clk/2, mtime counts its rising edges
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q    <= 1'b0;
      rtc_d1_q <= 1'b0;
    end else begin
      rtc_q    <= ~rtc_q;
      rtc_d1_q <= rtc_q;
    end
  end

  assign rtc_tick = rtc_q & ~rtc_d1_q;

  // ----------------------------------------
  // timer registers
  // ----------------------------------------
  always_comb begin
    mtime_d = mtime_q;
    if (rtc_tick) begin
      mtime_d.val = mtime_q.val + 64'd1;
    end
    // bus write beats the tick for that half
    if (wr_en && offset_i == clint_mtime_off) begin
      mtime_d.half.lo = wdata_i;
    end
    if (wr_en && offset_i == clint_mtime_off + 32'd4) begin
      mtime_d.half.hi = wdata_i;
    end
  end

  always_comb begin
    mtimecmp_d = mtimecmp_q;
    if (wr_en && offset_i == clint_mtimecmp_off) begin
      mtimecmp_d.half.lo = wdata_i;
    end
    if (wr_en && offset_i == clint_mtimecmp_off + 32'd4) begin
      mtimecmp_d.half.hi = wdata_i;
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      if (wr_en && offset_i == clint_msip_off) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  // ----------------------------------------
  // read port
  // ----------------------------------------
  always_comb begin
    rd_data = '0;
    case (offset_i)
      clint_msip_off:             rd_data[0] = msip_q;
      clint_mtimecmp_off:         rd_data = mtimecmp_q.half.lo;
      clint_mtimecmp_off + 32'd4: rd_data = mtimecmp_q.half.hi;
      clint_mtime_off:            rd_data = mtime_q.half.lo;
      clint_mtime_off + 32'd4:    rd_data = mtime_q.half.hi;
      default:                    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_q <= rd_data;
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = mtime_q.val >= mtimecmp_q.val;
  assign ipi_o       = msip_q;

endmodule

// ==== logic/plic.sv ====
// platform interrupt controller: level gateways, priorities, claim/complete, one target
`timescale 1ns/1ps

module plic #(
  parameter int unsigned num_sources = soc_pkg::num_sources_default,
  parameter int unsigned prio_w      = soc_pkg::prio_w
) (
  input  logic                           clk,
  input  logic                           ndmreset_n,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [soc_pkg::bus_addr_w-1:0] offset_i,
  input  logic [soc_pkg::bus_data_w-1:0] wdata_i,
  input  logic [num_sources-1:0]         irq_sources_i,
  output logic [soc_pkg::bus_data_w-1:0] rdata_o,
  output logic                           eip_o
);
  import soc_pkg::*;

  localparam int unsigned id_w = $clog2(num_sources + 1);

  logic                   wr_en;
  logic                   rd_en;
  logic                   claim;
  logic                   complete;
  logic [prio_w-1:0]      prio_q [num_sources];
  logic [num_sources-1:0] enable_q;
  logic [prio_w-1:0]      threshold_q;
  logic [num_sources-1:0] pending_q;
  logic [num_sources-1:0] in_flight_q;
  logic [num_sources-1:0] claim_mask;
  logic [num_sources-1:0] complete_mask;
  logic [id_w-1:0]        best_id;
  logic [prio_w-1:0]      best_prio;
  logic                   eip_q;
  logic [bus_data_w-1:0]  rd_data;
  logic [bus_data_w-1:0]  rdata_q;

  assign wr_en    = req_i & we_i;
  assign rd_en    = req_i & ~we_i;
  assign claim    = rd_en && offset_i == plic_claim_off;
  assign complete = wr_en && offset_i == plic_claim_off;

  // ----------------------------------------
  // arbitration
  // ----------------------------------------
  // strict compare keeps the lowest id on ties, prio 0 never wins
  always_comb begin
    best_id   = '0;
    best_prio = '0;
    for (int i = 0; i < num_sources; i++) begin
      if (pending_q[i] && enable_q[i] && prio_q[i] > best_prio) begin
        best_id   = id_w'(i + 1);
        best_prio = prio_q[i];
      end
    end
  end

  always_comb begin
    claim_mask    = '0;
    complete_mask = '0;
    for (int i = 0; i < num_sources; i++) begin
      if (claim && best_id == id_w'(i + 1)) begin
        claim_mask[i] = 1'b1;
      end
      if (complete && wdata_i == i + 1) begin
        complete_mask[i] = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // gateways and registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      for (int i = 0; i < num_sources; i++) begin
        prio_q[i] <= '0;
      end
      enable_q    <= '0;
      threshold_q <= '0;
      pending_q   <= '0;
      in_flight_q <= '0;
      eip_q       <= 1'b0;
    end else begin
      for (int i = 0; i < num_sources; i++) begin
        if (wr_en && offset_i == 4 * (i + 1)) begin
          prio_q[i] <= wdata_i[prio_w-1:0];
        end
      end
      if (wr_en && offset_i == plic_enable_off) begin
        enable_q <= wdata_i[num_sources:1];
      end
      if (wr_en && offset_i == plic_threshold_off) begin
        threshold_q <= wdata_i[prio_w-1:0];
      end
      // a level re-arms only after its complete
      pending_q   <= (pending_q | (irq_sources_i & ~in_flight_q)) & ~claim_mask;
      in_flight_q <= (in_flight_q | claim_mask) & ~complete_mask;
      eip_q       <= best_prio > threshold_q;
    end
  end

  // ----------------------------------------
  // read port
  // ----------------------------------------
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < num_sources; i++) begin
      if (offset_i == 4 * (i + 1)) begin
        rd_data[prio_w-1:0] = prio_q[i];
      end
    end
    if (offset_i == plic_pending_off) begin
      rd_data[num_sources:1] = pending_q;
    end
    if (offset_i == plic_enable_off) begin
      rd_data[num_sources:1] = enable_q;
    end
    if (offset_i == plic_threshold_off) begin
      rd_data[prio_w-1:0] = threshold_q;
    end
    if (offset_i == plic_claim_off) begin
      rd_data[id_w-1:0] = best_id;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_q <= rd_data;
    end
  end

  assign rdata_o = rdata_q;
  assign eip_o   = eip_q;

endmodule

// ==== logic/periph_shell.sv ====
// peripheral shell: bus decoder with boot rom, clint and plic behind it
`timescale 1ns/1ps

module periph_shell #(
  parameter int unsigned num_sources = soc_pkg::num_sources_default,
  parameter int unsigned prio_w      = soc_pkg::prio_w
) (
  input  logic                           clk,
  input  logic                           ndmreset_n,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [soc_pkg::bus_addr_w-1:0] addr_i,
  input  logic [soc_pkg::bus_data_w-1:0] wdata_i,
  input  logic [num_sources-1:0]         irq_sources_i,
  output logic [soc_pkg::bus_data_w-1:0] rdata_o,
  output logic                           rvalid_o,
  output logic                           err_o,
  output logic                           timer_irq_o,
  output logic                           ipi_o,
  output logic                           eip_o
);
  import soc_pkg::*;

  logic                  rom_req;
  logic                  clint_req;
  logic                  plic_req;
  logic                  tgt_we;
  logic [bus_addr_w-1:0] tgt_offset;
  logic [bus_data_w-1:0] tgt_wdata;
  logic [bus_data_w-1:0] rom_rdata;
  logic [bus_data_w-1:0] clint_rdata;
  logic [bus_data_w-1:0] plic_rdata;

  periph_decode u_decode (
    .clk           ( clk         ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .wdata_i       ( wdata_i     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .plic_rdata_i  ( plic_rdata  ),
    .rom_req_o     ( rom_req     ),
    .clint_req_o   ( clint_req   ),
    .plic_req_o    ( plic_req    ),
    .we_o          ( tgt_we      ),
    .offset_o      ( tgt_offset  ),
    .wdata_o       ( tgt_wdata   ),
    .rdata_o       ( rdata_o     ),
    .rvalid_o      ( rvalid_o    ),
    .err_o         ( err_o       )
  );

  boot_rom u_rom (
    .clk      ( clk        ),
    .req_i    ( rom_req    ),
    .offset_i ( tgt_offset ),
    .rdata_o  ( rom_rdata  )
  );

  clint u_clint (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( clint_req   ),
    .we_i        ( tgt_we      ),
    .offset_i    ( tgt_offset  ),
    .wdata_i     ( tgt_wdata   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  plic #(
    .num_sources ( num_sources ),
    .prio_w      ( prio_w      )
  ) u_plic (
    .clk           ( clk           ),
    .ndmreset_n    ( ndmreset_n    ),
    .req_i         ( plic_req      ),
    .we_i          ( tgt_we        ),
    .offset_i      ( tgt_offset    ),
    .wdata_i       ( tgt_wdata     ),
    .irq_sources_i ( irq_sources_i ),
    .rdata_o       ( plic_rdata    ),
    .eip_o         ( eip_o         )
  );

endmodule

// ==== verif/tb_vectors.svh ====
// test vector table for the peripheral shell testbench: bus ops, sources and expected levels
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

  // idle: data is a cycle count, then irq levels are checked
  localparam logic [2:0] op_idle     = 3'd0;
  localparam logic [2:0] op_src      = 3'd1;
  localparam logic [2:0] op_read     = 3'd2;
  localparam logic [2:0] op_write    = 3'd3;
  // data is the number of lfsr-picked rom reads
  localparam logic [2:0] op_rom_rand = 3'd4;
  localparam logic [2:0] op_nz       = 3'd5;
  localparam logic [2:0] op_mark     = 3'd6;
  localparam logic [2:0] op_delta    = 3'd7;

  typedef struct packed {
    logic [2:0]  op;
    logic        b2b;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    logic        err;
    logic [2:0]  irq;
  } vec_t;

  localparam int unsigned n_vec = 45;

  // columns: op, back-to-back, addr, data, rdata, err, irq {eip, ipi, timer}
  vec_t vec_tab [n_vec] = '{
    '{op_rom_rand, 1'b0, 32'h0000_0000, 32'd12,        32'h0, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0001_0004, 32'hdead_beef, 32'h0, 1'b1, 3'b000},
    '{op_read,     1'b0, 32'h4000_0000, 32'h0,         32'h0, 1'b1, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd20,        32'h0, 1'b0, 3'b000},
    // mtime
    '{op_nz,       1'b0, 32'h0200_bff8, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_mark,     1'b0, 32'h0200_bff8, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd100,       32'h0, 1'b0, 3'b000},
    '{op_delta,    1'b0, 32'h0200_bff8, 32'h0,         32'h0, 1'b0, 3'b000},
    // mtimecmp
    '{op_write,    1'b0, 32'h0200_4004, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0200_4000, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd2,         32'h0, 1'b0, 3'b001},
    '{op_write,    1'b0, 32'h0200_4000, 32'hffff_ffff, 32'h0, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0200_4004, 32'hffff_ffff, 32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd2,         32'h0, 1'b0, 3'b000},
    // msip
    '{op_write,    1'b0, 32'h0200_0000, 32'h1,         32'h0, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0200_0000, 32'h0,         32'h1, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd2,         32'h0, 1'b0, 3'b010},
    '{op_write,    1'b0, 32'h0200_0000, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0200_0000, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd2,         32'h0, 1'b0, 3'b000},
    // plic setup, sources 3 and 6
    '{op_write,    1'b0, 32'h0c00_000c, 32'h5,         32'h0, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0c00_0018, 32'h5,         32'h0, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0c00_2000, 32'h48,        32'h0, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0c20_0000, 32'h2,         32'h0, 1'b0, 3'b000},
    '{op_src,      1'b0, 32'h0000_0000, 32'h24,        32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd3,         32'h0, 1'b0, 3'b100},
    '{op_read,     1'b0, 32'h0c00_1000, 32'h0,         32'h48, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0c20_0004, 32'h0,         32'h3, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0c20_0004, 32'h0,         32'h6, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0c20_0004, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd2,         32'h0, 1'b0, 3'b000},
    // source 6 stays in flight until complete
    '{op_src,      1'b0, 32'h0000_0000, 32'h00,        32'h0, 1'b0, 3'b000},
    '{op_src,      1'b0, 32'h0000_0000, 32'h20,        32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd3,         32'h0, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0c00_1000, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0c20_0004, 32'h0,         32'h0, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0c20_0004, 32'h6,         32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd3,         32'h0, 1'b0, 3'b100},
    '{op_read,     1'b0, 32'h0c00_1000, 32'h0,         32'h40, 1'b0, 3'b000},
    '{op_write,    1'b0, 32'h0c20_0000, 32'h5,         32'h0, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd3,         32'h0, 1'b0, 3'b000},
    // back-to-back rom, clint, plic
    '{op_read,     1'b1, 32'h0001_0008, 32'h0,         32'hf140_2573, 1'b0, 3'b000},
    '{op_read,     1'b1, 32'h0200_4000, 32'h0,         32'hffff_ffff, 1'b0, 3'b000},
    '{op_read,     1'b0, 32'h0c00_000c, 32'h0,         32'h5, 1'b0, 3'b000},
    '{op_idle,     1'b0, 32'h0000_0000, 32'd2,         32'h0, 1'b0, 3'b000}
  };

`endif

// ==== verif/tb_periph_shell.sv ====
// table-driven bus and interrupt testbench for the peripheral shell
`timescale 1ns/1ps

module tb_periph_shell;
  import soc_pkg::*;

  localparam int unsigned num_sources = num_sources_default;

  logic                   clk;
  logic                   ndmreset_n;
  logic                   req_i;
  logic                   we_i;
  logic [bus_addr_w-1:0]  addr_i;
  logic [bus_data_w-1:0]  wdata_i;
  logic [num_sources-1:0] irq_sources_i;
  logic [bus_data_w-1:0]  rdata_o;
  logic                   rvalid_o;
  logic                   err_o;
  logic                   timer_irq_o;
  logic                   ipi_o;
  logic                   eip_o;

  `include "tb_vectors.svh"

  localparam int unsigned max_cycles = n_vec * 8 + 200;

  logic [31:0] lfsr = 32'h6eaa_1af2;
  logic [31:0] mark_val;
  int unsigned cycles = 0;

  periph_shell #(
    .num_sources ( num_sources ),
    .prio_w      ( prio_w      )
  ) uut (
    .clk           ( clk           ),
    .ndmreset_n    ( ndmreset_n    ),
    .req_i         ( req_i         ),
    .we_i          ( we_i          ),
    .addr_i        ( addr_i        ),
    .wdata_i       ( wdata_i       ),
    .irq_sources_i ( irq_sources_i ),
    .rdata_o       ( rdata_o       ),
    .rvalid_o      ( rvalid_o      ),
    .err_o         ( err_o         ),
    .timer_irq_o   ( timer_irq_o   ),
    .ipi_o         ( ipi_o         ),
    .eip_o         ( eip_o         )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: no end of test after %0d cycles", max_cycles);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] bits);
    bits = '0;
    for (int unsigned b = 0; b < n; b++) begin
      bits[b] = lfsr[0];
      lfsr    = lfsr_next(lfsr);
    end
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive(input logic we, input logic [31:0] addr, input logic [31:0] data);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = data;
  endtask

  task automatic release_bus();
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic check_levels(input logic [2:0] irq);
    check("rvalid_o", 32'd0, 32'(rvalid_o));
    check("eip_o", 32'(irq[2]), 32'(eip_o));
    check("ipi_o", 32'(irq[1]), 32'(ipi_o));
    check("timer_irq_o", 32'(irq[0]), 32'(timer_irq_o));
  endtask

  task automatic check_response(input logic [2:0] op, input logic [31:0] exp, input logic err);
    logic [31:0] delta;
    check("rvalid_o", 32'd1, 32'(rvalid_o));
    check("err_o", 32'(err), 32'(err_o));
    case (op)
      op_nz: check("mtime_lo nonzero", 32'd1, 32'(rdata_o != '0));
      op_mark: mark_val = rdata_o;
      op_delta: begin
        // rtc runs at half the clock rate
        delta = rdata_o - mark_val;
        if (delta != 32'd51) begin
          check("mtime_lo delta", 32'd50, delta);
        end
      end
      default: check("rdata_o", exp, rdata_o);
    endcase
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    vec_t        v;
    logic [31:0] bits;
    logic        pend;
    logic [2:0]  p_op;
    logic [31:0] p_exp;
    logic        p_err;
    ndmreset_n    = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    irq_sources_i = '0;
    pend          = 1'b0;
    p_op          = op_read;
    p_exp         = '0;
    p_err         = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    ndmreset_n = 1'b1;

    for (int i = 0; i < n_vec; i++) begin
      v = vec_tab[i];
      case (v.op)
        op_idle: begin
          repeat (v.data) @(posedge clk);
          #1;
          check_levels(v.irq);
        end
        op_src: begin
          next_cycle();
          irq_sources_i = v.data[num_sources-1:0];
        end
        op_rom_rand: begin
          for (int unsigned k = 0; k < v.data; k++) begin
            take_bits(4, bits);
            next_cycle();
            drive(1'b0, rom_base + (bits << 2), '0);
            next_cycle();
            release_bus();
            check_response(op_read, boot_image[bits[3:0]], 1'b0);
          end
        end
        default: begin
          next_cycle();
          // response of the previous back-to-back request
          if (pend) begin
            check_response(p_op, p_exp, p_err);
          end
          drive(v.op == op_write, v.addr, v.data);
          p_op  = v.op;
          p_exp = v.rdata;
          p_err = v.err;
          pend  = 1'b1;
          if (!v.b2b) begin
            next_cycle();
            release_bus();
            check_response(p_op, p_exp, p_err);
            pend = 1'b0;
          end
        end
      endcase
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+verif
logic/soc_pkg.sv
logic/periph_decode.sv
logic/boot_rom.sv
logic/clint.sv
logic/plic.sv
logic/periph_shell.sv
verif/tb_periph_shell.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_periph_shell -f list.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_periph_shell > sim.log 2>&1
cat sim.log
grep -q "^=== PASS ===$" sim.log && exit 0 || exit 1
